// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_top
FILELIST := src.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The run passes only when the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/tb_model.svh ====
// ------------------------------------------------
// Reference model of the peripheral slice
// Included inside the testbench module; mirrors the
// device table, the GPIO output register and the
// reset register, and holds the typed compare tasks
// ------------------------------------------------

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [GPIO_COUNT-1:0] gp_out_sh = '0;
logic [1:0]            rst_reg_sh = '0;

function automatic data_t merge_bytes(data_t old_v, data_t new_v, sel_t sel);
	data_t res;
	res = old_v;
	for (int b = 0; b < 4; b++) begin
		if (sel[b]) begin
			res[8*b +: 8] = new_v[8*b +: 8];
		end
	end
	return res;
endfunction

// Slot k holds the id at word 2k and the size in bytes at word 2k+1
function automatic data_t devtbl_word(int unsigned off);
	int unsigned ids [3];
	int unsigned sizes [3];
	data_t       w;
	ids = '{DEVTBL_ID, GPIO_ID, INVALID_ID};
	sizes = '{DEVTBL_MAPSZ, GPIO_MAPSZ, INVALID_MAPSZ};
	w = '0;
	if (off == RST_REG_OFFSET) begin
		w = data_t'(rst_reg_sh);
	end else if (off < 6 && off % 2 == 0) begin
		w = ids[off / 2];
		// GPIO is the only slave flagged as an interrupt user
		if (off / 2 == 1) begin
			w[31] = 1'b1;
		end
	end else if (off < 6) begin
		w = sizes[off / 2] * 4;
	end
	return w;
endfunction

function automatic pi1_rsp_t model_access(pi1_req_t r);
	pi1_rsp_t    rsp;
	data_t       old_v;
	data_t       new_v;
	int unsigned a;
	logic        wr;
	a = 32'(r.addr);
	wr = (r.op == WRITE || r.op == SWAP);
	old_v = '0;
	if (a < DEVTBL_MAPSZ) begin
		old_v = devtbl_word(a);
		if (wr && a == RST_REG_OFFSET) begin
			new_v = merge_bytes(old_v, r.data, r.sel);
			rst_reg_sh = new_v[1:0];
		end
	end else if (a == DEVTBL_MAPSZ) begin
		old_v = data_t'(gp_i);
	end else if (a == DEVTBL_MAPSZ + 1) begin
		old_v = data_t'(gp_out_sh);
		if (wr) begin
			new_v = merge_bytes(old_v, r.data, r.sel);
			gp_out_sh = new_v[GPIO_COUNT-1:0];
		end
	end
	// Other GPIO words and the invalid region read 0 and drop writes
	rsp.data = (r.op == READ || r.op == SWAP) ? old_v : '0;
	return rsp;
endfunction

function automatic void model_reset();
	gp_out_sh = '0;
	rst_reg_sh = '0;
endfunction

task automatic compare_rsp(pi1_rsp_t got, pi1_rsp_t exp, string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERROR at %0t: %s is %h, expected %h", $time, what, got.data, exp.data);
	end
endtask

task automatic compare_gpio(logic [GPIO_COUNT-1:0] got, logic [GPIO_COUNT-1:0] exp,
	string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic compare_flag(logic got, logic exp, string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

`endif

// ==== dv/tb_top.sv ====
// ------------------------------------------------
// Testbench of the peripheral slice
// Acts as the credit-based bus master with xorshift
// stimulus, checks every response in order against
// the model and exercises warm reset and power-off
// ------------------------------------------------

module tb_top;

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	localparam logic [31:0] SEED = 32'h2e5d_3692;
	localparam int unsigned GPIO_BATCHES = 4;
	localparam int unsigned GPIO_OPS = 9;
	localparam int unsigned INVALID_OPS = 16;
	localparam int unsigned BP_OPS = 40;
	// Requests over all tests including five from the reset tests
	localparam int unsigned TOTAL_REQS = DEVTBL_MAPSZ + GPIO_BATCHES * GPIO_OPS +
		INVALID_OPS + 8 + BP_OPS + 5;
	localparam int unsigned TIMEOUT_CYC = 40 * TOTAL_REQS + 200;

	logic                  clk_4x_w;
	logic                  rst_p;
	logic                  req_valid_i;
	pi1_req_t              req_i;
	logic                  req_crd_o;
	logic                  rsp_valid_o;
	pi1_rsp_t              rsp_o;
	logic                  rsp_crd_i;
	logic [GPIO_COUNT-1:0] gp_i;
	logic [GPIO_COUNT-1:0] gp_o;
	logic                  rst_busy_o;
	logic                  pwr_off_o;

	pi1_req_t    send_q[$];
	pi1_rsp_t    exp_q[$];
	pi1_req_t    cur_req;
	pi1_rsp_t    exp_rsp;
	logic [31:0] stim_rng;
	logic [31:0] flow_rng;
	logic        bp_mode = 1'b0;
	logic        rst_allowed = 1'b1;
	logic        busy_prev = 1'b0;
	int          cycles = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          err_mark = 0;
	int          issued = 0;
	int          rsp_count = 0;
	int          req_credits = 0;
	int          owed = 0;
	int          outstanding = 0;

	`include "tb_model.svh"

	soc_periph_top dut (
		.clk_4x_w    (clk_4x_w),
		.rst_p       (rst_p),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.req_crd_o   (req_crd_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o),
		.rsp_crd_i   (rsp_crd_i),
		.gp_i        (gp_i),
		.gp_o        (gp_o),
		.rst_busy_o  (rst_busy_o),
		.pwr_off_o   (pwr_off_o)
	);

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] draw_stim();
		stim_rng = xorshift32(stim_rng);
		return stim_rng;
	endfunction

	function automatic void queue_req(pi1_op_e op, int unsigned addr, data_t data, sel_t sel);
		pi1_req_t rq;
		rq.op = op;
		rq.addr = addr_t'(addr);
		rq.data = data;
		rq.sel = sel;
		send_q.push_back(rq);
	endfunction

	// Idle means every request answered and every response credit returned
	task automatic drain();
		do @(negedge clk_4x_w);
		while (send_q.size() != 0 || exp_q.size() != 0 || owed != 0);
	endtask

	task automatic wait_reset_done();
		do @(negedge clk_4x_w);
		while (rst_busy_o !== 1'b0);
	endtask

	task automatic test_done(string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			$display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin
		clk_4x_w = 1'b0;
		forever #50 clk_4x_w = ~clk_4x_w;
	end

	// Master side with response check, credit return and request issue
	always @(posedge clk_4x_w) begin
		cycles++;
		flow_rng = xorshift32(flow_rng);
		if (rsp_valid_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Response at %0t arrived with no request outstanding", $time);
			end else begin
				exp_rsp = exp_q.pop_front();
				compare_rsp(rsp_o, exp_rsp, "response data");
			end
			rsp_count++;
			owed++;
			outstanding--;
		end
		if (req_crd_o === 1'b1) begin
			req_credits++;
		end
		// Any reset refills request credits and reloads the DUT response credits
		if (rst_busy_o !== 1'b0) begin
			if (!rst_allowed && !busy_prev) begin
				errors++;
				$display("Reset started at %0t without a reset request", $time);
			end
			req_credits = REQ_DEPTH;
			owed = 0;
			outstanding = 0;
			exp_q.delete();
			model_reset();
		end
		busy_prev = (rst_busy_o !== 1'b0);
		if (owed > 0 && (!bp_mode || flow_rng[2:1] == 2'b00)) begin
			rsp_crd_i <= 1'b1;
			owed--;
		end else begin
			rsp_crd_i <= 1'b0;
		end
		if (rst_busy_o === 1'b0 && req_credits > 0 && send_q.size() != 0 &&
			(bp_mode || flow_rng[0])) begin
			cur_req = send_q.pop_front();
			exp_q.push_back(model_access(cur_req));
			req_i <= cur_req;
			req_valid_i <= 1'b1;
			req_credits--;
			outstanding++;
			issued++;
			if (outstanding > REQ_DEPTH) begin
				errors++;
				$display("More than %0d requests outstanding at %0t", REQ_DEPTH, $time);
			end
		end else begin
			req_valid_i <= 1'b0;
		end
	end

	initial begin
		wait (cycles >= TIMEOUT_CYC);
		$display("Timeout after %0d cycles, %0d responses still missing", cycles, exp_q.size());
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [31:0] r;
		stim_rng = SEED;
		flow_rng = xorshift32(~SEED);
		rst_p = 1'b1;
		req_valid_i = 1'b0;
		req_i = '0;
		rsp_crd_i = 1'b0;
		gp_i = '0;
		repeat (4) @(posedge clk_4x_w);
		rst_p <= 1'b0;
		wait_reset_done();
		rst_allowed = 1'b0;

		for (int i = 0; i < DEVTBL_MAPSZ; i++) begin
			queue_req(READ, i, draw_stim(), 4'hf);
		end
		drain();
		test_done("device table");

		for (int b = 0; b < GPIO_BATCHES; b++) begin
			@(posedge clk_4x_w);
			gp_i <= GPIO_COUNT'(draw_stim());
			@(negedge clk_4x_w);
			queue_req(READ, DEVTBL_MAPSZ, '0, 4'hf);
			for (int i = 1; i < GPIO_OPS; i++) begin
				r = draw_stim();
				case (r[1:0])
					2'd0: queue_req(WRITE, DEVTBL_MAPSZ + 1, draw_stim(), r[7:4]);
					2'd1: queue_req(SWAP, DEVTBL_MAPSZ + 1, draw_stim(), r[7:4]);
					2'd2: queue_req(READ, DEVTBL_MAPSZ + 1, '0, 4'hf);
					default: queue_req(READ, DEVTBL_MAPSZ + (r >> 8) % GPIO_MAPSZ, '0, 4'hf);
				endcase
			end
			drain();
			compare_gpio(gp_o, gp_out_sh, "gp_o");
		end
		test_done("GPIO");

		for (int i = 0; i < INVALID_OPS; i++) begin
			r = draw_stim();
			queue_req(pi1_op_e'(r[1:0]), DEVTBL_MAPSZ + GPIO_MAPSZ + (r >> 8) % INVALID_MAPSZ,
				draw_stim(), r[7:4]);
		end
		// State of the real slaves must be untouched
		queue_req(READ, DEVTBL_MAPSZ + 1, '0, 4'hf);
		for (int i = 0; i < 6; i++) begin
			queue_req(READ, i, '0, 4'hf);
		end
		queue_req(READ, RST_REG_OFFSET, '0, 4'hf);
		drain();
		compare_gpio(gp_o, gp_out_sh, "gp_o");
		test_done("invalid region");

		bp_mode = 1'b1;
		for (int i = 0; i < BP_OPS; i++) begin
			r = draw_stim();
			case (r[1:0])
				2'd0: queue_req(READ, (r >> 8) % DEVTBL_MAPSZ, '0, 4'hf);
				2'd1: queue_req(pi1_op_e'(r[3:2]), DEVTBL_MAPSZ + (r >> 8) % GPIO_MAPSZ,
					draw_stim(), r[7:4]);
				default: queue_req(pi1_op_e'(r[3:2]),
					DEVTBL_MAPSZ + GPIO_MAPSZ + (r >> 8) % INVALID_MAPSZ, draw_stim(), r[7:4]);
			endcase
		end
		drain();
		bp_mode = 1'b0;
		if (req_credits != REQ_DEPTH || issued != rsp_count) begin
			errors++;
			$display("Request credits out of balance: %0d held, %0d issued, %0d answered",
				req_credits, issued, rsp_count);
		end
		compare_gpio(gp_o, gp_out_sh, "gp_o");
		test_done("back-pressure");

		queue_req(WRITE, DEVTBL_MAPSZ + 1, draw_stim() | 32'h1, 4'hf);
		drain();
		compare_gpio(gp_o, gp_out_sh, "gp_o before warm reset");
		rst_allowed = 1'b1;
		queue_req(WRITE, RST_REG_OFFSET, 32'h2, 4'hf);
		drain();
		wait_reset_done();
		rst_allowed = 1'b0;
		queue_req(READ, DEVTBL_MAPSZ + 1, '0, 4'hf);
		drain();
		compare_gpio(gp_o, '0, "gp_o after warm reset");
		compare_flag(pwr_off_o, 1'b0, "pwr_off_o after warm reset");
		test_done("warm reset");

		rst_allowed = 1'b1;
		queue_req(WRITE, RST_REG_OFFSET, 32'h1, 4'hf);
		drain();
		repeat (50) begin
			@(negedge clk_4x_w);
			compare_flag(pwr_off_o, 1'b1, "pwr_off_o while powered off");
			compare_flag(rst_busy_o, 1'b1, "rst_busy_o while powered off");
		end
		@(posedge clk_4x_w);
		rst_p <= 1'b1;
		repeat (4) @(posedge clk_4x_w);
		rst_p <= 1'b0;
		@(negedge clk_4x_w);
		compare_flag(pwr_off_o, 1'b0, "pwr_off_o after rst_p");
		wait_reset_done();
		queue_req(READ, RST_REG_OFFSET, '0, 4'hf);
		drain();
		test_done("power-off");

		$display("Tests %0d, requests %0d, responses %0d, checks %0d, errors %0d",
			tests_run, issued, rsp_count, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== hw/pi1_addr_decode.sv ====
// ------------------------------------------------
// First request stage of the peripheral bus
// Compares the word address against the map sizes,
// picks the target slave and strips the region base
// Output is registered, exactly one cycle of latency
// ------------------------------------------------

module pi1_addr_decode (
	input  logic                  clk_4x_w,
	input  logic                  rst_p,
	input  logic                  req_valid_i,
	input  pi1_bus_pkg::pi1_req_t req_i,
	output logic                  dec_valid_o,
	output soc_map_pkg::dev_req_t dec_o
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	slave_e slave_c;
	addr_t  base_c;
	addr_t  rel_c;

	// Contiguous regions with everything past GPIO in the catch-all
	always_comb begin
		if (req_i.addr < addr_t'(DEVTBL_MAPSZ)) begin
			slave_c = DEVTBL;
			base_c  = '0;
		end else if (req_i.addr < addr_t'(DEVTBL_MAPSZ + GPIO_MAPSZ)) begin
			slave_c = GPIO;
			base_c  = addr_t'(DEVTBL_MAPSZ);
		end else begin
			slave_c = INVALIDDEV;
			base_c  = addr_t'(DEVTBL_MAPSZ + GPIO_MAPSZ);
		end
	end

	assign rel_c = req_i.addr - base_c;

	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= req_valid_i;
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (req_valid_i) begin
			dec_o.op     <= req_i.op;
			dec_o.slave  <= slave_c;
			// Invalid region offsets wrap to 8 bits
			dec_o.offset <= offset_t'(rel_c);
			dec_o.data   <= req_i.data;
			dec_o.sel    <= req_i.sel;
		end
	end

	// Master must hold off while the reset sequencer keeps the bus in reset
	a_no_req_in_rst: assert property (@(posedge clk_4x_w) rst_p |-> !req_valid_i)
		else $error("request issued while bus held in reset");

endmodule

// ==== hw/pi1_bus_pkg.sv ====
// ------------------------------------------------
// PI1 bus definitions shared by every pipeline stage
// Holds the op encoding, the bus widths, the request
// and response words, and the credit counts of the
// master interface
// ------------------------------------------------

package pi1_bus_pkg;

	// Word address with the byte offset already dropped
	typedef logic [29:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] sel_t;

	// Same op encoding as the PI1 bus
	typedef enum logic [1:0] {
		NOP   = 2'b00,
		WRITE = 2'b01,
		READ  = 2'b10,
		SWAP  = 2'b11
	} pi1_op_e;

	typedef struct packed {
		pi1_op_e op;
		addr_t   addr;
		data_t   data;
		sel_t    sel;
	} pi1_req_t;

	typedef struct packed {
		data_t data;
	} pi1_rsp_t;

	// Request credits held by the master and depth of the response queue
	localparam int unsigned REQ_DEPTH = 4;

	// Response credits held by the DUT after reset
	localparam int unsigned RSP_CREDITS = 2;

	localparam int unsigned REQ_PTR_W = $clog2(REQ_DEPTH);
	localparam int unsigned REQ_CNT_W = $clog2(REQ_DEPTH + 1);
	localparam int unsigned RSP_CRD_W = $clog2(RSP_CREDITS + 1);

endpackage

// ==== hw/pi1_dev_exec.sv ====
// ------------------------------------------------
// Execute stage of the peripheral bus
// Serves the device table with its reset register,
// the GPIO block and the invalid-device catch-all
// Response data is registered one cycle after decode
// ------------------------------------------------

module pi1_dev_exec (
	input  logic                                  clk_4x_w,
	input  logic                                  rst_p,
	input  logic                                  dec_valid_i,
	input  soc_map_pkg::dev_req_t                 dec_i,
	input  logic [soc_map_pkg::GPIO_COUNT-1:0]    gp_i,
	output logic [soc_map_pkg::GPIO_COUNT-1:0]    gp_o,
	output logic                                  exec_valid_o,
	output pi1_bus_pkg::pi1_rsp_t                 exec_o,
	output logic [1:0]                            sw_rst_o,
	output logic                                  sw_rst_valid_o
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	logic [1:0]            rst_reg_q;
	logic [GPIO_COUNT-1:0] gp_out_q;
	data_t                 rd_data_c;
	data_t                 rst_merge_c;
	data_t                 gp_merge_c;
	logic                  wr_c;
	logic                  rd_c;
	logic                  rst_wr_c;
	logic                  gp_wr_c;

	// Replace only the byte lanes enabled by sel
	function automatic data_t lane_merge(data_t old_v, data_t new_v, sel_t sel);
		data_t mask;
		for (int i = 0; i < $bits(sel_t); i++) begin
			mask[8*i +: 8] = {8{sel[i]}};
		end
		return (old_v & ~mask) | (new_v & mask);
	endfunction

	always_comb begin
		rd_data_c = '0;
		case (dec_i.slave)
			DEVTBL: begin
				// Two words per slave, id then map size in bytes
				case (dec_i.offset)
					8'd0: rd_data_c = data_t'(DEVTBL_ID);
					8'd1: rd_data_c = data_t'(DEVTBL_MAPSZ * 4);
					8'd2: rd_data_c = data_t'(GPIO_ID) | 32'h8000_0000;
					8'd3: rd_data_c = data_t'(GPIO_MAPSZ * 4);
					8'd4: rd_data_c = data_t'(INVALID_ID);
					8'd5: rd_data_c = data_t'(INVALID_MAPSZ * 4);
					offset_t'(RST_REG_OFFSET): rd_data_c = data_t'(rst_reg_q);
					default: rd_data_c = '0;
				endcase
			end
			GPIO: begin
				// Word 0 is the input pins, word 1 the output register
				case (dec_i.offset)
					8'd0: rd_data_c = data_t'(gp_i);
					8'd1: rd_data_c = data_t'(gp_out_q);
					default: rd_data_c = '0;
				endcase
			end
			default: rd_data_c = '0;
		endcase
	end

	assign wr_c = dec_valid_i && (dec_i.op == WRITE || dec_i.op == SWAP);
	assign rd_c = (dec_i.op == READ || dec_i.op == SWAP);

	assign rst_wr_c = wr_c && dec_i.slave == DEVTBL &&
		dec_i.offset == offset_t'(RST_REG_OFFSET);
	assign gp_wr_c = wr_c && dec_i.slave == GPIO && dec_i.offset == 8'd1;

	assign rst_merge_c = lane_merge(data_t'(rst_reg_q), dec_i.data, dec_i.sel);
	assign gp_merge_c = lane_merge(data_t'(gp_out_q), dec_i.data, dec_i.sel);

	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			exec_valid_o <= 1'b0;
			sw_rst_valid_o <= 1'b0;
			rst_reg_q <= '0;
			gp_out_q <= '0;
		end else begin
			exec_valid_o <= dec_valid_i;
			sw_rst_valid_o <= rst_wr_c;
			if (rst_wr_c) begin
				rst_reg_q <= rst_merge_c[1:0];
			end
			if (gp_wr_c) begin
				gp_out_q <= gp_merge_c[GPIO_COUNT-1:0];
			end
		end
	end

	// Swap hands back the word from before the write
	always_ff @(posedge clk_4x_w) begin
		if (dec_valid_i) begin
			exec_o.data <= rd_c ? rd_data_c : '0;
		end
	end

	assign sw_rst_o = rst_reg_q;
	assign gp_o = gp_out_q;

endmodule

// ==== hw/pi1_rsp_credit.sv ====
// ------------------------------------------------
// Response stage of the peripheral bus
// Queues responses and sends them while the master
// has returned response credits, handing a request
// credit back with every response that leaves
// An empty queue is bypassed for one cycle latency
// ------------------------------------------------

module pi1_rsp_credit (
	input  logic                  clk_4x_w,
	input  logic                  rst_p,
	input  logic                  exec_valid_i,
	input  pi1_bus_pkg::pi1_rsp_t exec_i,
	input  logic                  rsp_crd_i,
	output logic                  rsp_valid_o,
	output pi1_bus_pkg::pi1_rsp_t rsp_o,
	output logic                  req_crd_o
);

	import pi1_bus_pkg::*;

	pi1_rsp_t             fifo_mem [REQ_DEPTH];
	logic [REQ_PTR_W-1:0] wr_ptr;
	logic [REQ_PTR_W-1:0] rd_ptr;
	logic [REQ_CNT_W-1:0] fifo_cnt;
	logic [RSP_CRD_W-1:0] crd_cnt;
	logic                 fifo_empty_c;
	logic                 send_c;
	logic                 push_c;
	logic                 pop_c;
	pi1_rsp_t             head_c;
	logic                 send_q;

	assign fifo_empty_c = (fifo_cnt == '0);
	assign send_c = (crd_cnt != '0) && (!fifo_empty_c || exec_valid_i);
	// Incoming word skips the queue when it leaves right away
	assign push_c = exec_valid_i && !(send_c && fifo_empty_c);
	assign pop_c = send_c && !fifo_empty_c;
	assign head_c = fifo_empty_c ? exec_i : fifo_mem[rd_ptr];

	always_ff @(posedge clk_4x_w) begin
		if (push_c) begin
			fifo_mem[wr_ptr] <= exec_i;
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
		end else begin
			if (push_c) begin
				wr_ptr <= (wr_ptr == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_c) begin
				rd_ptr <= (rd_ptr == REQ_PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_c, pop_c})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	// Master returns at most one credit per cycle
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			crd_cnt <= RSP_CRD_W'(RSP_CREDITS);
			send_q <= 1'b0;
		end else begin
			send_q <= send_c;
			case ({rsp_crd_i, send_c})
				2'b10: crd_cnt <= crd_cnt + 1'b1;
				2'b01: crd_cnt <= crd_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (send_c) begin
			rsp_o <= head_c;
		end
	end

	assign rsp_valid_o = send_q;
	assign req_crd_o = send_q;

	// Holds only if the master never exceeds its request credits
	a_no_push_full: assert property (@(posedge clk_4x_w) disable iff (rst_p)
		push_c |-> fifo_cnt < REQ_CNT_W'(REQ_DEPTH))
		else $error("response queue pushed while full");

	// Master must not return more response credits than it was given
	a_crd_bound: assert property (@(posedge clk_4x_w) disable iff (rst_p)
		crd_cnt <= RSP_CRD_W'(RSP_CREDITS))
		else $error("response credit counter above its reset value");

endmodule

// ==== hw/rst_sequencer.sv ====
// ------------------------------------------------
// Reset sequencer of the board slice
// Stretches the board reset with a down counter and
// decodes the software reset register bits into warm,
// cold and power-off requests
// ------------------------------------------------

module rst_sequencer (
	input  logic       clk_4x_w,
	input  logic       rst_p,
	input  logic [1:0] sw_rst_i,
	input  logic       sw_rst_valid_i,
	output logic       sys_rst_o,
	output logic       rst_busy_o,
	output logic       pwr_off_o
);

	import soc_map_pkg::*;

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic                      pwr_off_q;
	logic                      sw_cold_c;
	logic                      sw_warm_c;
	logic                      sw_pwroff_c;
	logic                      sys_rst_c;

	assign sw_cold_c = sw_rst_valid_i && (sw_rst_i == 2'b11);
	assign sw_warm_c = sw_rst_valid_i && (sw_rst_i == 2'b10);
	assign sw_pwroff_c = sw_rst_valid_i && (sw_rst_i == 2'b01);

	// Cold reset has no global set/reset here and runs like a warm one
	always_ff @(posedge clk_4x_w) begin
		if (rst_p || sw_cold_c || sw_warm_c) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off sticks until the board reset
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (sw_pwroff_c) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_c = rst_p || pwr_off_q || (rst_cntr != '0);

	assign sys_rst_o = sys_rst_c;
	assign rst_busy_o = sys_rst_c;
	assign pwr_off_o = pwr_off_q;

endmodule

// ==== hw/soc_map_pkg.sv ====
// ------------------------------------------------
// Peripheral address map of the board slice
// Lists the slaves, their sizes and device ids, the
// reset register location and the decoded request
// passed from the decode stage to the execute stage
// ------------------------------------------------

package soc_map_pkg;

	// Order matches the device table slot of each slave
	typedef enum logic [1:0] {
		DEVTBL     = 2'd0,
		GPIO       = 2'd1,
		INVALIDDEV = 2'd2
	} slave_e;

	// Word offset inside a slave region
	typedef logic [7:0] offset_t;

	typedef struct packed {
		pi1_bus_pkg::pi1_op_e op;
		slave_e               slave;
		offset_t              offset;
		pi1_bus_pkg::data_t   data;
		pi1_bus_pkg::sel_t    sel;
	} dev_req_t;

	// Region sizes in words with the device table based at address 0
	localparam int unsigned DEVTBL_MAPSZ  = 64;
	localparam int unsigned GPIO_MAPSZ    = 16;
	localparam int unsigned INVALID_MAPSZ = 1024;

	// Ids reported through the device table
	localparam int unsigned DEVTBL_ID  = 7;
	localparam int unsigned GPIO_ID    = 6;
	localparam int unsigned INVALID_ID = 0;

	// Device table word holding the software reset bits
	localparam int unsigned RST_REG_OFFSET = 62;

	localparam int unsigned GPIO_COUNT = 8;

	// Reset is held for 2**RST_CNTR_BITSZ - 1 cycles
	localparam int unsigned RST_CNTR_BITSZ = 4;

endpackage

// ==== hw/soc_periph_top.sv ====
// ------------------------------------------------
// Peripheral slice top level
// Chains decode, execute and response stages on the
// credit-based request/response ports and drives all
// stages from the reset sequencer
// ------------------------------------------------

module soc_periph_top (
	input  logic                               clk_4x_w,
	input  logic                               rst_p,
	input  logic                               req_valid_i,
	input  pi1_bus_pkg::pi1_req_t              req_i,
	output logic                               req_crd_o,
	output logic                               rsp_valid_o,
	output pi1_bus_pkg::pi1_rsp_t              rsp_o,
	input  logic                               rsp_crd_i,
	input  logic [soc_map_pkg::GPIO_COUNT-1:0] gp_i,
	output logic [soc_map_pkg::GPIO_COUNT-1:0] gp_o,
	output logic                               rst_busy_o,
	output logic                               pwr_off_o
);

	import pi1_bus_pkg::*;
	import soc_map_pkg::*;

	logic       sys_rst_w;
	logic       dec_valid_w;
	dev_req_t   dec_w;
	logic       exec_valid_w;
	pi1_rsp_t   exec_w;
	logic [1:0] sw_rst_w;
	logic       sw_rst_valid_w;

	pi1_addr_decode u_decode (
		.clk_4x_w    (clk_4x_w),
		.rst_p       (sys_rst_w),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.dec_valid_o (dec_valid_w),
		.dec_o       (dec_w)
	);

	pi1_dev_exec u_exec (
		.clk_4x_w       (clk_4x_w),
		.rst_p          (sys_rst_w),
		.dec_valid_i    (dec_valid_w),
		.dec_i          (dec_w),
		.gp_i           (gp_i),
		.gp_o           (gp_o),
		.exec_valid_o   (exec_valid_w),
		.exec_o         (exec_w),
		.sw_rst_o       (sw_rst_w),
		.sw_rst_valid_o (sw_rst_valid_w)
	);

	pi1_rsp_credit u_rsp (
		.clk_4x_w     (clk_4x_w),
		.rst_p        (sys_rst_w),
		.exec_valid_i (exec_valid_w),
		.exec_i       (exec_w),
		.rsp_crd_i    (rsp_crd_i),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o),
		.req_crd_o    (req_crd_o)
	);

	// Runs from the board reset so a software reset can release itself
	rst_sequencer u_rst_seq (
		.clk_4x_w       (clk_4x_w),
		.rst_p          (rst_p),
		.sw_rst_i       (sw_rst_w),
		.sw_rst_valid_i (sw_rst_valid_w),
		.sys_rst_o      (sys_rst_w),
		.rst_busy_o     (rst_busy_o),
		.pwr_off_o      (pwr_off_o)
	);

endmodule

// ==== src.f ====
+incdir+dv
hw/pi1_bus_pkg.sv
hw/soc_map_pkg.sv
hw/pi1_addr_decode.sv
hw/pi1_dev_exec.sv
hw/pi1_rsp_credit.sv
hw/rst_sequencer.sv
hw/soc_periph_top.sv
dv/tb_top.sv
